//--- Bender.yml
package:
  name: sample_discriminator

sources:
  - source/disc_pkg.sv
  - source/disc_control.sv
  - source/level_compare.sv
  - source/hysteresis_gate.sv
  - source/timestamp_counter.sv
  - source/sample_discriminator.sv
  - target: test
    files:
      - tb/sample_discriminator_tb.sv

//--- source/disc_control.sv
`timescale 1ns/1ps

module disc_control (
  input  logic                                                            clk,
  input  logic                                                            reset,
  input  logic                                                            config_valid,
  input  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0]     threshold_high,
  input  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0]     threshold_low,
  input  logic                                                            reset_state,
  output logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0]     thr_high,
  output logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0]     thr_low,
  output logic                                                            state_clear
);

  // both threshold buses are loaded together, so every channel switches on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      thr_high <= '0;
      thr_low <= '0;
    end else if (config_valid) begin
      thr_high <= threshold_high;
      thr_low <= threshold_low;
    end
  end

  // the clear pulse is retimed here and fanned out to every channel
  always_ff @(posedge clk) begin
    if (reset) begin
      state_clear <= 1'b0;
    end else begin
      state_clear <= reset_state;
    end
  end

  // a low threshold above the high one would let a word be both above and below,
  // which the gate cannot resolve
  for (genvar i = 0; i < disc_pkg::n_channels; i++) begin : g_thr_check
    a_thr_order: assert property (
      @(posedge clk) disable iff (reset)
      config_valid |=> ($signed(thr_low[i]) <= $signed(thr_high[i]))
    ) else $error("channel %0d loaded low threshold above high threshold", i);
  end

  // reset_state is a single-cycle request
  a_clear_pulse: assert property (
    @(posedge clk) disable iff (reset)
    state_clear |=> !state_clear
  ) else $error("state_clear held for more than one cycle");

endmodule

//--- source/disc_pkg.sv
package disc_pkg;

  // channel and word geometry of the digitizer front end
  localparam int n_channels = 2;
  localparam int sample_width = 16;
  localparam int parallel_samples = 4;
  localparam int word_width = sample_width * parallel_samples;

  // the timestamp holds the word timer in the upper bits and the forwarded index below
  localparam int sample_index_width = 14;
  localparam int clock_width = 50;
  localparam int timestamp_width = clock_width + sample_index_width;

  // hysteresis state of one channel
  typedef enum logic {
    st_quiet  = 1'b0,
    st_active = 1'b1
  } chan_state_e;

endpackage

//--- source/hysteresis_gate.sv
`timescale 1ns/1ps

module hysteresis_gate (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            state_clear,
  input  logic [disc_pkg::word_width-1:0] word_q,
  input  logic                            word_valid_q,
  input  logic                            any_above,
  input  logic                            all_below,
  output logic [disc_pkg::word_width-1:0] data_out,
  output logic                            data_out_valid,
  output logic                            event_start
);

  disc_pkg::chan_state_e state;
  disc_pkg::chan_state_e cur_state;
  disc_pkg::chan_state_e next_state;

  // a clear arriving together with a word means that word is judged from quiet
  always_comb begin
    cur_state = state_clear ? disc_pkg::st_quiet : state;
    next_state = cur_state;
    if (word_valid_q) begin
      if (any_above) begin
        next_state = disc_pkg::st_active;
      end else if (all_below) begin
        next_state = disc_pkg::st_quiet;
      end
    end
  end

  // event_start is combinational so the timestamp lands on the same edge as the data
  assign event_start = word_valid_q && (cur_state == disc_pkg::st_quiet) &&
                       (next_state == disc_pkg::st_active);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= disc_pkg::st_quiet;
      data_out_valid <= 1'b0;
    end else begin
      state <= next_state;
      data_out_valid <= word_valid_q && (next_state == disc_pkg::st_active);
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid_q) begin
      data_out <= word_q;
    end
  end

  // both flags at once can only come from a low threshold loaded above the high one
  a_flags_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    word_valid_q |-> !(any_above && all_below)
  ) else $error("word flagged both above high and below low");

endmodule

//--- source/level_compare.sv
`timescale 1ns/1ps

module level_compare (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [disc_pkg::word_width-1:0]   word,
  input  logic                              word_valid,
  input  logic [disc_pkg::sample_width-1:0] thr_high,
  input  logic [disc_pkg::sample_width-1:0] thr_low,
  output logic [disc_pkg::word_width-1:0]   word_q,
  output logic                              word_valid_q,
  output logic                              any_above,
  output logic                              all_below
);

  logic [disc_pkg::parallel_samples-1:0] above;
  logic [disc_pkg::parallel_samples-1:0] below;

  // samples are two's complement, so the comparison is signed
  always_comb begin
    logic signed [disc_pkg::sample_width-1:0] sample;
    for (int j = 0; j < disc_pkg::parallel_samples; j++) begin
      sample = word[j*disc_pkg::sample_width +: disc_pkg::sample_width];
      above[j] = sample > $signed(thr_high);
      below[j] = sample < $signed(thr_low);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      word_valid_q <= 1'b0;
    end else begin
      word_valid_q <= word_valid;
    end
  end

  // the word and its two reduced flags follow the input on every edge
  always_ff @(posedge clk) begin
    word_q <= word;
    any_above <= |above;
    all_below <= &below;
  end

endmodule

//--- source/sample_discriminator.sv
`timescale 1ns/1ps

module sample_discriminator (
  input  logic                                                          clk,
  input  logic                                                          reset,
  input  logic [disc_pkg::n_channels-1:0][disc_pkg::word_width-1:0]     data_in,
  input  logic [disc_pkg::n_channels-1:0]                               data_in_valid,
  input  logic                                                          config_valid,
  input  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0]   threshold_high,
  input  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0]   threshold_low,
  input  logic                                                          reset_state,
  output logic [disc_pkg::n_channels-1:0][disc_pkg::word_width-1:0]     data_out,
  output logic [disc_pkg::n_channels-1:0]                               data_out_valid,
  output logic [disc_pkg::n_channels-1:0][disc_pkg::timestamp_width-1:0] timestamp_out,
  output logic [disc_pkg::n_channels-1:0]                               timestamp_valid
);

  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0] thr_high;
  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0] thr_low;
  logic                                                        state_clear;

  disc_control u_control (
    .clk            (clk),
    .reset          (reset),
    .config_valid   (config_valid),
    .threshold_high (threshold_high),
    .threshold_low  (threshold_low),
    .reset_state    (reset_state),
    .thr_high       (thr_high),
    .thr_low        (thr_low),
    .state_clear    (state_clear)
  );

  // each channel is an independent compare, gate and timestamp chain
  for (genvar i = 0; i < disc_pkg::n_channels; i++) begin : g_chan
    logic [disc_pkg::word_width-1:0] word_q;
    logic                            word_valid_q;
    logic                            any_above;
    logic                            all_below;
    logic                            event_start;

    level_compare u_compare (
      .clk          (clk),
      .reset        (reset),
      .word         (data_in[i]),
      .word_valid   (data_in_valid[i]),
      .thr_high     (thr_high[i]),
      .thr_low      (thr_low[i]),
      .word_q       (word_q),
      .word_valid_q (word_valid_q),
      .any_above    (any_above),
      .all_below    (all_below)
    );

    hysteresis_gate u_gate (
      .clk            (clk),
      .reset          (reset),
      .state_clear    (state_clear),
      .word_q         (word_q),
      .word_valid_q   (word_valid_q),
      .any_above      (any_above),
      .all_below      (all_below),
      .data_out       (data_out[i]),
      .data_out_valid (data_out_valid[i]),
      .event_start    (event_start)
    );

    timestamp_counter u_timestamp (
      .clk             (clk),
      .reset           (reset),
      .state_clear     (state_clear),
      .word_valid_q    (word_valid_q),
      .data_out_valid  (data_out_valid[i]),
      .event_start     (event_start),
      .timestamp_out   (timestamp_out[i]),
      .timestamp_valid (timestamp_valid[i])
    );
  end

endmodule

//--- source/timestamp_counter.sv
`timescale 1ns/1ps

module timestamp_counter (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 state_clear,
  input  logic                                 word_valid_q,
  input  logic                                 data_out_valid,
  input  logic                                 event_start,
  output logic [disc_pkg::timestamp_width-1:0] timestamp_out,
  output logic                                 timestamp_valid
);

  logic [disc_pkg::clock_width-1:0]        timer;
  logic [disc_pkg::sample_index_width-1:0] index;
  logic [disc_pkg::sample_index_width-1:0] index_now;

  // data_out_valid lags its word by one edge, so a forwarded word is counted
  // one cycle after the gate decides on it
  // an event never follows a forwarded word unless a clear sits between them,
  // so the pending count does not have to be added here
  assign index_now = state_clear ? '0 : index;

  // the timer runs over every word and ignores the state clear
  always_ff @(posedge clk) begin
    if (reset) begin
      timer <= '0;
    end else if (word_valid_q) begin
      timer <= timer + 1'b1;
    end
  end

  // a pending forward from before the clear is dropped along with the old count
  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
    end else if (state_clear) begin
      index <= '0;
    end else if (data_out_valid) begin
      index <= index + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      timestamp_valid <= 1'b0;
    end else begin
      timestamp_valid <= event_start;
    end
  end

  // values from before the event word is counted
  always_ff @(posedge clk) begin
    if (event_start) begin
      timestamp_out <= {timer, index_now};
    end
  end

endmodule

//--- tb/disc_patterns.txt
# one phase per line, all values signed decimal
# ch0 high low min max, ch1 high low min max, word count, clear after phase (1 = yes)
# ch0 strong pulse above high, ch1 held below low
1000 -1000 2000 30000   1000 -1000 -30000 -2000   40 0
# both channels straddle their thresholds
1000 -1000 -3000 1500   1000 -1000 -1800 1400   200 0
# new thresholds, ch0 narrow band and ch1 wide band
200 100 -400 600   5000 -5000 -7000 5500   200 1
# samples equal to a threshold do not cross it
0 0 -20 20   -100 -200 -400 100   150 1
# ch0 full scale, ch1 with equal thresholds
32000 -32000 -32768 32767   300 300 250 350   150 0
# ch0 falls quiet and stays there, ch1 stays active
100 50 -1000 -500   100 50 400 900   30 1
# index restarts after the clear while the timer runs on
100 50 200 900   100 50 -900 900   60 0

//--- tb/sample_discriminator_tb.sv
`timescale 1ns/1ps

module sample_discriminator_tb;

  logic clk;
  logic reset;
  logic [disc_pkg::n_channels-1:0][disc_pkg::word_width-1:0] data_in;
  logic [disc_pkg::n_channels-1:0] data_in_valid;
  logic config_valid;
  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0] threshold_high;
  logic [disc_pkg::n_channels-1:0][disc_pkg::sample_width-1:0] threshold_low;
  logic reset_state;
  logic [disc_pkg::n_channels-1:0][disc_pkg::word_width-1:0] data_out;
  logic [disc_pkg::n_channels-1:0] data_out_valid;
  logic [disc_pkg::n_channels-1:0][disc_pkg::timestamp_width-1:0] timestamp_out;
  logic [disc_pkg::n_channels-1:0] timestamp_valid;

  // reference model of each channel
  disc_pkg::chan_state_e model_state [disc_pkg::n_channels];
  logic [disc_pkg::clock_width-1:0] model_timer [disc_pkg::n_channels];
  logic [disc_pkg::sample_index_width-1:0] model_index [disc_pkg::n_channels];
  int thr_hi [disc_pkg::n_channels];
  int thr_lo [disc_pkg::n_channels];
  int range_lo [disc_pkg::n_channels];
  int range_hi [disc_pkg::n_channels];

  // expected outputs indexed by their due cycle modulo 4
  logic sched_data_valid [disc_pkg::n_channels][4];
  logic [disc_pkg::word_width-1:0] sched_data [disc_pkg::n_channels][4];
  logic sched_ts_valid [disc_pkg::n_channels][4];
  logic [disc_pkg::timestamp_width-1:0] sched_ts [disc_pkg::n_channels][4];
  int pending;
  int cycle;
  logic [31:0] lfsr;

  sample_discriminator UUT (
    .clk             (clk),
    .reset           (reset),
    .data_in         (data_in),
    .data_in_valid   (data_in_valid),
    .config_valid    (config_valid),
    .threshold_high  (threshold_high),
    .threshold_low   (threshold_low),
    .reset_state     (reset_state),
    .data_out        (data_out),
    .data_out_valid  (data_out_valid),
    .timestamp_out   (timestamp_out),
    .timestamp_valid (timestamp_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // maps random bits onto the closed range lo to hi
  function automatic logic [15:0] fold_sample(input logic [31:0] r, input int lo, input int hi);
    int v;
    v = lo + int'(r % (hi - lo + 1));
    return v[15:0];
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  // applies the hysteresis rule to one word and schedules its result two cycles after the drive
  task automatic model_word(input int ch, input logic [disc_pkg::word_width-1:0] w);
    logic above;
    logic below;
    logic signed [15:0] s;
    disc_pkg::chan_state_e prev;
    int slot;
    above = 1'b0;
    below = 1'b1;
    for (int j = 0; j < disc_pkg::parallel_samples; j++) begin
      s = w[j*16 +: 16];
      if (s > thr_hi[ch]) above = 1'b1;
      if (!(s < thr_lo[ch])) below = 1'b0;
    end
    prev = model_state[ch];
    if (above) begin
      model_state[ch] = disc_pkg::st_active;
    end else if (below) begin
      model_state[ch] = disc_pkg::st_quiet;
    end
    slot = (cycle + 2) % 4;
    if (prev == disc_pkg::st_quiet && model_state[ch] == disc_pkg::st_active) begin
      sched_ts_valid[ch][slot] = 1'b1;
      sched_ts[ch][slot] = {model_timer[ch], model_index[ch]};
      pending++;
    end
    if (model_state[ch] == disc_pkg::st_active) begin
      sched_data_valid[ch][slot] = 1'b1;
      sched_data[ch][slot] = w;
      model_index[ch] = model_index[ch] + 1'b1;
      pending++;
    end
    model_timer[ch] = model_timer[ch] + 1'b1;
  endtask

  task automatic check_outputs();
    int slot;
    slot = cycle % 4;
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      check_value($sformatf("data_out_valid[%0d]", ch), data_out_valid[ch],
                  sched_data_valid[ch][slot]);
      if (sched_data_valid[ch][slot]) begin
        check_value($sformatf("data_out[%0d]", ch), data_out[ch], sched_data[ch][slot]);
        pending--;
      end
      check_value($sformatf("timestamp_valid[%0d]", ch), timestamp_valid[ch],
                  sched_ts_valid[ch][slot]);
      if (sched_ts_valid[ch][slot]) begin
        check_value($sformatf("timestamp_out[%0d]", ch), timestamp_out[ch], sched_ts[ch][slot]);
        pending--;
      end
      sched_data_valid[ch][slot] = 1'b0;
      sched_ts_valid[ch][slot] = 1'b0;
    end
  endtask

  // outputs are looked at mid-cycle, well away from the drive time
  always @(posedge clk) begin
    if (!reset) begin
      #4;
      check_outputs();
    end
  end

  task automatic drive_idle();
    @(posedge clk);
    #1;
    data_in_valid = '0;
    config_valid = 1'b0;
    reset_state = 1'b0;
  endtask

  task automatic load_thresholds();
    drive_idle();
    config_valid = 1'b1;
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      threshold_high[ch] = thr_hi[ch][15:0];
      threshold_low[ch] = thr_lo[ch][15:0];
    end
  endtask

  // a channel skips a word about one cycle in eight
  task automatic drive_words();
    logic [disc_pkg::word_width-1:0] w;
    drive_idle();
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      if (take_bits(3) != 0) begin
        for (int j = 0; j < disc_pkg::parallel_samples; j++) begin
          w[j*16 +: 16] = fold_sample(take_bits(16), range_lo[ch], range_hi[ch]);
        end
        data_in[ch] = w;
        data_in_valid[ch] = 1'b1;
        model_word(ch, w);
      end
    end
  endtask

  task automatic wait_drain();
    int idle;
    idle = 0;
    while (pending != 0 || idle < 3) begin
      drive_idle();
      idle++;
      if (idle > 20) begin
        fail_run($sformatf("timeout with %0d expected outputs never seen", pending));
      end
    end
  endtask

  task automatic clear_state();
    drive_idle();
    reset_state = 1'b1;
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      model_state[ch] = disc_pkg::st_quiet;
      model_index[ch] = '0;
    end
  endtask

  initial begin
    int fd;
    int n;
    int words;
    int do_clear;
    int phases;
    logic [8*200-1:0] line;
    reset = 1'b1;
    data_in = '0;
    data_in_valid = '0;
    config_valid = 1'b0;
    threshold_high = '0;
    threshold_low = '0;
    reset_state = 1'b0;
    lfsr = 32'h7a4a;
    pending = 0;
    cycle = 0;
    phases = 0;
    for (int ch = 0; ch < disc_pkg::n_channels; ch++) begin
      model_state[ch] = disc_pkg::st_quiet;
      model_timer[ch] = '0;
      model_index[ch] = '0;
      for (int s = 0; s < 4; s++) begin
        sched_data_valid[ch][s] = 1'b0;
        sched_ts_valid[ch][s] = 1'b0;
      end
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    fd = $fopen("tb/disc_patterns.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the pattern file tb/disc_patterns.txt");
    end
    while (!$feof(fd)) begin
      line = '0;
      void'($fgets(line, fd));
      n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", thr_hi[0], thr_lo[0], range_lo[0],
                  range_hi[0], thr_hi[1], thr_lo[1], range_lo[1], range_hi[1], words, do_clear);
      if (n == 10) begin
        phases++;
        load_thresholds();
        for (int k = 0; k < words; k++) begin
          drive_words();
        end
        wait_drain();
        if (do_clear != 0) begin
          clear_state();
        end
      end
    end
    $fclose(fd);
    wait_drain();
    if (phases == 0 || pending != 0) begin
      fail_run("no test phase was run or expected outputs are still missing");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- vlog.f
source/disc_pkg.sv
source/disc_control.sv
source/level_compare.sv
source/hysteresis_gate.sv
source/timestamp_counter.sv
source/sample_discriminator.sv
tb/sample_discriminator_tb.sv
